//--- hdl/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

	// one colour sample, unsigned
	typedef logic [7:0] channel_t;

	// red sits in the top byte, blue in the bottom byte
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} rgb_t;

	// 3x3 neighbourhood, top row first, left column first
	// bottom_right is always the newest pixel
	typedef struct packed {
		rgb_t top_left;
		rgb_t top_centre;
		rgb_t top_right;
		rgb_t middle_left;
		rgb_t middle_centre;
		rgb_t middle_right;
		rgb_t bottom_left;
		rgb_t bottom_centre;
		rgb_t bottom_right;
	} window_t;

	// range -4*255 .. 5*255 needs 12 signed bits
	typedef logic signed [11:0] acc_t;

	// sharpen kernel weights
	localparam acc_t COEF_CENTER = 12'sd5;
	localparam acc_t COEF_EDGE = -12'sd1;
	localparam acc_t COEF_CORNER = 12'sd0;

	// saturation ceiling of one channel
	localparam acc_t CHANNEL_MAX = 12'sd255;

endpackage

`default_nettype wire

//--- hdl/frame_pkg.sv
`default_nettype none

package frame_pkg;

	// real image size
	localparam int IMG_WIDTH = 8;
	localparam int IMG_HEIGHT = 6;

	// kernel half-width, one ring of zeros around the image
	localparam int BORDER = 1;

	// padded frame as the source sends it
	localparam int PAD_WIDTH = IMG_WIDTH + 2 * BORDER;
	localparam int PAD_HEIGHT = IMG_HEIGHT + 2 * BORDER;

	// position inside the padded frame
	typedef logic [3:0] col_t;
	typedef logic [3:0] row_t;

	// per-window flags that travel beside the data
	// interior: window centre is a real image pixel
	// last: window closed by the final pixel of the frame
	typedef struct packed {
		logic interior;
		logic last;
	} tag_t;

endpackage

`default_nettype wire

//--- hdl/line_window.sv
`timescale 1ns/1ns
`default_nettype none

module line_window (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_adv,
	input wire pixel_pkg::rgb_t i_pixel,
	output pixel_pkg::window_t o_window
);
	import pixel_pkg::*;
	import frame_pkg::*;

	// row delay lines, index 0 holds the newest entry
	rgb_t [PAD_WIDTH-1:0] line_mid;
	rgb_t [PAD_WIDTH-1:0] line_top;

	// pixel one row up and two rows up from i_pixel
	rgb_t mid_tap;
	rgb_t top_tap;

	window_t win_q;

	assign mid_tap = line_mid[PAD_WIDTH-1];
	assign top_tap = line_top[PAD_WIDTH-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			line_mid <= '0;
			line_top <= '0;
			win_q <= '0;
		end else if (i_adv) begin
			// second line chains off the first one
			line_mid <= {line_mid[PAD_WIDTH-2:0], i_pixel};
			line_top <= {line_top[PAD_WIDTH-2:0], mid_tap};

			// slide all three rows one column to the left
			win_q.top_left <= win_q.top_centre;
			win_q.top_centre <= win_q.top_right;
			win_q.top_right <= top_tap;
			win_q.middle_left <= win_q.middle_centre;
			win_q.middle_centre <= win_q.middle_right;
			win_q.middle_right <= mid_tap;
			win_q.bottom_left <= win_q.bottom_centre;
			win_q.bottom_centre <= win_q.bottom_right;
			win_q.bottom_right <= i_pixel;
		end
	end

	assign o_window = win_q;

	// only strobed pixels reach the window, so it stays known once fed
	a_window_known: assert property (
		@(posedge clk) disable iff (reset)
		i_adv |=> !$isunknown(o_window)
	) else $error("line_window: window holds unknown samples");

endmodule

`default_nettype wire

//--- hdl/frame_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module frame_tracker (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_adv,
	output frame_pkg::tag_t o_tag
);
	import frame_pkg::*;

	// position of the next pixel to be taken
	col_t col_q;
	row_t row_q;

	tag_t tag_q;

	logic col_end;
	logic row_end;

	assign col_end = (col_q == col_t'(PAD_WIDTH - 1));
	assign row_end = (row_q == row_t'(PAD_HEIGHT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			col_q <= '0;
			row_q <= '0;
			tag_q <= '0;
		end else if (i_adv) begin
			// centre sits one row up and one column left of this pixel
			tag_q.interior <= (row_q >= row_t'(2 * BORDER))
				&& (col_q >= col_t'(2 * BORDER));
			// final pixel of the padded frame closes the last real window
			tag_q.last <= row_end && col_end;

			// raster walk, wraps back to the origin at frame end
			if (col_end) begin
				col_q <= '0;
				if (row_end) begin
					row_q <= '0;
				end else begin
					row_q <= row_q + 1'b1;
				end
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

	assign o_tag = tag_q;

	a_pos_range: assert property (
		@(posedge clk) disable iff (reset)
		(col_q < col_t'(PAD_WIDTH)) && (row_q < row_t'(PAD_HEIGHT))
	) else $error("frame_tracker: position outside padded frame");

endmodule

`default_nettype wire

//--- hdl/kernel_stage.sv
`timescale 1ns/1ns
`default_nettype none

module kernel_stage (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_adv,
	input wire pixel_pkg::window_t i_window,
	input wire frame_pkg::tag_t i_tag,
	output logic o_valid,
	output pixel_pkg::rgb_t o_pixel,
	output logic o_last
);
	import pixel_pkg::*;
	import frame_pkg::*;

	// sum stage then clamp stage
	localparam int KERNEL_STAGES = 2;

	acc_t sum_d [3];
	acc_t sum_q [3];
	channel_t [2:0] pix_q;

	tag_t tag_q [KERNEL_STAGES];

	// high in the cycle after stage 2 took a new result
	logic adv_q;

	// zero-extend one sample and apply its weight
	function automatic acc_t weigh(input channel_t sample, input acc_t coef);
		acc_t ext;
		ext = acc_t'({4'b0000, sample});
		return ext * coef;
	endfunction

	// saturate to 0..255
	function automatic channel_t clamp(input acc_t sum);
		if (sum < 0) begin
			return '0;
		end else if (sum > CHANNEL_MAX) begin
			return channel_t'(CHANNEL_MAX);
		end
		return sum[7:0];
	endfunction

	// channel 2 is red, 0 is blue
	for (genvar c = 0; c < 3; c++) begin : g_chan
		assign sum_d[c] = weigh(i_window.middle_centre[8*c +: 8], COEF_CENTER)
			+ weigh(i_window.top_centre[8*c +: 8], COEF_EDGE)
			+ weigh(i_window.middle_left[8*c +: 8], COEF_EDGE)
			+ weigh(i_window.middle_right[8*c +: 8], COEF_EDGE)
			+ weigh(i_window.bottom_centre[8*c +: 8], COEF_EDGE)
			+ weigh(i_window.top_left[8*c +: 8], COEF_CORNER)
			+ weigh(i_window.top_right[8*c +: 8], COEF_CORNER)
			+ weigh(i_window.bottom_left[8*c +: 8], COEF_CORNER)
			+ weigh(i_window.bottom_right[8*c +: 8], COEF_CORNER);
	end

	// data path
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int c = 0; c < 3; c++) begin
				sum_q[c] <= '0;
				pix_q[c] <= '0;
			end
		end else if (i_adv) begin
			for (int c = 0; c < 3; c++) begin
				sum_q[c] <= sum_d[c];
				pix_q[c] <= clamp(sum_q[c]);
			end
		end
	end

	// flags follow the data stage for stage
	always_ff @(posedge clk) begin
		if (reset) begin
			adv_q <= 1'b0;
			for (int s = 0; s < KERNEL_STAGES; s++) begin
				tag_q[s] <= '0;
			end
		end else begin
			adv_q <= i_adv;
			if (i_adv) begin
				tag_q[0] <= i_tag;
				for (int s = 1; s < KERNEL_STAGES; s++) begin
					tag_q[s] <= tag_q[s-1];
				end
			end
		end
	end

	assign o_pixel = pix_q;
	assign o_valid = adv_q && tag_q[KERNEL_STAGES-1].interior;
	assign o_last = adv_q && tag_q[KERNEL_STAGES-1].last;

	// tracker marks the frame end only on an interior window
	a_last_valid: assert property (
		@(posedge clk) disable iff (reset)
		o_last |-> o_valid
	) else $error("kernel_stage: last marker without valid pixel");

endmodule

`default_nettype wire

//--- hdl/sharpen_filter_top.sv
`timescale 1ns/1ns
`default_nettype none

module sharpen_filter_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_valid,
	input wire pixel_pkg::rgb_t i_pixel,
	output logic o_valid,
	output pixel_pkg::rgb_t o_pixel,
	output logic o_last
);
	import pixel_pkg::*;
	import frame_pkg::*;

	// registered strobe, every block steps only on it
	logic adv;
	rgb_t pix;

	window_t window;
	tag_t tag;

	// pixel bus sampled every cycle, blocks take it only when adv is high
	always_ff @(posedge clk) begin
		if (reset) begin
			adv <= 1'b0;
			pix <= '0;
		end else begin
			adv <= i_valid;
			pix <= i_pixel;
		end
	end

	// window and tag load on the same advance, so they stay aligned
	line_window u_window (
		.clk (clk),
		.reset (reset),
		.i_adv (adv),
		.i_pixel (pix),
		.o_window (window)
	);

	frame_tracker u_tracker (
		.clk (clk),
		.reset (reset),
		.i_adv (adv),
		.o_tag (tag)
	);

	kernel_stage u_kernel (
		.clk (clk),
		.reset (reset),
		.i_adv (adv),
		.i_window (window),
		.i_tag (tag),
		.o_valid (o_valid),
		.o_pixel (o_pixel),
		.o_last (o_last)
	);

endmodule

`default_nettype wire

//--- bench/sharpen_checker.sv
`timescale 1ns/1ns
`default_nettype none

module sharpen_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic i_in_valid,
	input wire pixel_pkg::rgb_t i_in_pixel,
	input wire logic i_out_valid,
	input wire pixel_pkg::rgb_t i_out_pixel,
	input wire logic i_out_last,
	output int o_tests,
	output int o_failed,
	output int o_errors,
	output int o_pending
);
	import pixel_pkg::*;
	import frame_pkg::*;

	// padded frame as it arrives, then the pixels it must produce
	rgb_t pad [PAD_WIDTH*PAD_HEIGHT];
	rgb_t exp_q [$];
	int in_count;
	int out_count;
	int test_errs;
	// input strobes seen at the last two edges
	bit [1:0] strobe_hist;
	bit reset_seen;
	bit reset_done;

	// sharpened value at padded position (r, c), each channel clamped to 0..255
	function automatic rgb_t sharpen_ref(input int r, input int c);
		int kern [3][3];
		int sum;
		int idx;
		rgb_t res;
		kern = '{'{0, -1, 0}, '{-1, 5, -1}, '{0, -1, 0}};
		res = '0;
		for (int ch = 0; ch < 3; ch++) begin
			sum = 0;
			for (int dr = 0; dr < 3; dr++) begin
				for (int dc = 0; dc < 3; dc++) begin
					idx = (r + dr - 1) * PAD_WIDTH + (c + dc - 1);
					sum += kern[dr][dc] * int'(pad[idx][8*ch +: 8]);
				end
			end
			if (sum < 0) begin
				sum = 0;
			end else if (sum > 255) begin
				sum = 255;
			end
			res[8*ch +: 8] = sum[7:0];
		end
		return res;
	endfunction

	task automatic count_error();
		o_errors++;
		test_errs++;
	endtask

	task automatic compare(input string name, input logic [23:0] act, input logic [23:0] exp);
		if (act !== exp) begin
			$display("[ERROR] t=%0t ns %s expected %0h actual %0h", $time, name, exp, act);
			count_error();
		end
	endtask

	// one line per finished test
	task automatic close_test(input string name);
		o_tests++;
		if (test_errs != 0) begin
			o_failed++;
		end
		$display("test %0d %s: %0d errors, %s", o_tests, name, test_errs,
			(test_errs == 0) ? "ok" : "FAIL");
		test_errs = 0;
	endtask

	always @(posedge clk) begin
		logic last_exp;
		int row;
		int col;
		if (reset) begin
			// first edge in reset may still show power-up values
			if (reset_seen && (i_out_valid !== 1'b0 || i_out_last !== 1'b0)) begin
				$display("error at %0t ns: output strobe high during reset", $time);
				count_error();
			end
			reset_seen = 1'b1;
			strobe_hist = '0;
		end else begin
			// o_valid needs a strobe two edges back
			if (i_out_valid && !strobe_hist[1]) begin
				$display("error at %0t ns: o_valid without an earlier input strobe", $time);
				count_error();
			end
			if (i_out_last && !i_out_valid) begin
				$display("error at %0t ns: o_last without o_valid", $time);
				count_error();
			end
			if (i_out_valid && exp_q.size() == 0) begin
				$display("error at %0t ns: o_valid with no expected pixel left", $time);
				count_error();
			end else if (i_out_valid) begin
				out_count++;
				// marker only on the final real pixel of a frame
				last_exp = (out_count == IMG_WIDTH * IMG_HEIGHT);
				compare("o_pixel", i_out_pixel, exp_q.pop_front());
				compare("o_last", {23'd0, i_out_last}, {23'd0, last_exp});
				if (last_exp) begin
					close_test($sformatf("frame %0d", o_tests));
					out_count = 0;
				end
			end
			// reset test ends at the first strobe
			if (i_in_valid && !reset_done) begin
				close_test("reset state");
				reset_done = 1'b1;
			end
			if (i_in_valid) begin
				pad[in_count] = i_in_pixel;
				// this pixel closes the window centred one row up and one column left
				row = in_count / PAD_WIDTH - BORDER;
				col = in_count % PAD_WIDTH - BORDER;
				if (row >= BORDER && col >= BORDER) begin
					exp_q.push_back(sharpen_ref(row, col));
				end
				in_count++;
				if (in_count == PAD_WIDTH * PAD_HEIGHT) begin
					in_count = 0;
				end
			end
			strobe_hist = {strobe_hist[0], i_in_valid};
		end
		o_pending = exp_q.size();
	end

endmodule

`default_nettype wire

//--- bench/tb_sharpen_filter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sharpen_filter;
	import pixel_pkg::*;
	import frame_pkg::*;

	localparam int FRAMES = 6;
	localparam logic [31:0] SEED = 32'h82ca;
	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	// longest idle run before a strobe, two random bits
	localparam int MAX_GAP = 3;
	localparam int FRAME_PIXELS = PAD_WIDTH * PAD_HEIGHT;
	// frames plus the two flush strobes
	localparam int TOTAL_STROBES = FRAMES * FRAME_PIXELS + 2;
	localparam int MARGIN_CYCLES = 64;
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + TOTAL_STROBES * (MAX_GAP + 1) + MARGIN_CYCLES) * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset;
	logic i_valid;
	rgb_t i_pixel;
	logic o_valid;
	rgb_t o_pixel;
	logic o_last;
	int tests;
	int failed;
	int errors;
	int pending;
	logic [31:0] lfsr = SEED;
	rgb_t pad_frame [FRAME_PIXELS];

	always #(CLK_PERIOD / 2) clk = ~clk;

	sharpen_filter_top dut0 (
		.clk (clk),
		.reset (reset),
		.i_valid (i_valid),
		.i_pixel (i_pixel),
		.o_valid (o_valid),
		.o_pixel (o_pixel),
		.o_last (o_last)
	);

	sharpen_checker chk0 (
		.clk (clk),
		.reset (reset),
		.i_in_valid (i_valid),
		.i_in_pixel (i_pixel),
		.i_out_valid (o_valid),
		.i_out_pixel (o_pixel),
		.i_out_last (o_last),
		.o_tests (tests),
		.o_failed (failed),
		.o_errors (errors),
		.o_pending (pending)
	);

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// msb first, one step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// junk on the bus, ignored without a strobe
	task automatic idle_cycle();
		logic [31:0] v;
		take_bits(24, v);
		@(negedge clk);
		i_valid = 1'b0;
		i_pixel = rgb_t'(v[23:0]);
	endtask

	task automatic strobe(input rgb_t pix);
		@(negedge clk);
		i_valid = 1'b1;
		i_pixel = pix;
	endtask

	// random image with one white row and one black row, zero ring around it
	task automatic build_frame();
		logic [31:0] v;
		int white_row;
		int black_row;
		int r;
		int c;
		take_bits(3, v);
		white_row = BORDER + int'(v) % IMG_HEIGHT;
		take_bits(3, v);
		black_row = BORDER + (white_row - BORDER + 1 + int'(v) % (IMG_HEIGHT - 1)) % IMG_HEIGHT;
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			r = i / PAD_WIDTH;
			c = i % PAD_WIDTH;
			take_bits(24, v);
			if (r < BORDER || r >= BORDER + IMG_HEIGHT
				|| c < BORDER || c >= BORDER + IMG_WIDTH) begin
				pad_frame[i] = '0;
			end else if (r == white_row) begin
				pad_frame[i] = '1;
			end else if (r == black_row) begin
				pad_frame[i] = '0;
			end else begin
				pad_frame[i] = rgb_t'(v[23:0]);
			end
		end
	endtask

	// gapped frames idle 0..MAX_GAP cycles before each strobe
	task automatic send_frame(input bit gapped);
		logic [31:0] gap;
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			gap = '0;
			if (gapped) begin
				take_bits(2, gap);
			end
			repeat (int'(gap)) idle_cycle();
			strobe(pad_frame[i]);
		end
	endtask

	initial begin
		logic [31:0] mode;
		reset = 1'b1;
		i_valid = 1'b0;
		i_pixel = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		// quiet spell before the first strobe
		repeat (4) idle_cycle();
		for (int f = 0; f < FRAMES; f++) begin
			build_frame();
			// one back to back and one gapped frame first, then random
			mode = 32'(f);
			if (f > 1) begin
				take_bits(1, mode);
			end
			send_frame(mode[0]);
		end
		// start of a zero frame pushes the last windows out
		strobe('0);
		strobe('0);
		idle_cycle();
		// reset test plus one test per frame
		wait (tests == FRAMES + 1);
		repeat (4) idle_cycle();
		$display("tests %0d, failed %0d, errors %0d, pixels never seen %0d",
			tests, failed, errors, pending);
		if (errors == 0 && failed == 0 && pending == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// worst case is every strobe behind a full gap
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: frames still unfinished after %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sharpen_filter_top.f
hdl/pixel_pkg.sv
hdl/frame_pkg.sv
hdl/line_window.sv
hdl/frame_tracker.sv
hdl/kernel_stage.sv
hdl/sharpen_filter_top.sv
bench/sharpen_checker.sv
bench/tb_sharpen_filter.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_sharpen_filter
FILELIST ?= sharpen_filter_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
